/* dcache.f */
rtl/dcachePkg.sv
rtl/dcacheCtrl.sv
rtl/dcacheFrames.sv
rtl/dcache.sv
test/dcache_properties.sv
test/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - rtl/dcachePkg.sv
  - rtl/dcacheCtrl.sv
  - rtl/dcacheFrames.sv
  - rtl/dcache.sv
  - target: test
    files:
      - test/dcache_properties.sv
      - test/dcache_tb.sv

/* test/dcache_tb.sv */
`default_nettype none

module dcache_tb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [1:0] {opRead, opWrite, opSnoop, opFlush} opT;
  typedef struct packed {
    opT          op;
    logic [31:0] addr;
    logic [31:0] data;   // bit 0 is ccinv for a snoop
    logic [3:0]  nRd;
    logic [3:0]  nWr;
  } stepT;

  localparam int NSTEPS = 19;
  localparam logic [31:0] POLY = 32'h8020_0003;

  stepT steps [NSTEPS] = '{
    '{opRead,  32'h0000_0010, 32'h0000_0000, 4'd2, 4'd0},  // cold miss
    '{opRead,  32'h0000_0014, 32'h0000_0000, 4'd0, 4'd0},
    '{opWrite, 32'h0000_0014, 32'hCAFE_0001, 4'd0, 4'd0},
    '{opRead,  32'h0000_0094, 32'h0000_0000, 4'd2, 4'd2},  // dirty victim
    '{opRead,  32'h0000_0014, 32'h0000_0000, 4'd2, 4'd0},
    '{opWrite, 32'h0000_0020, 32'hBEEF_0002, 4'd2, 4'd0},
    '{opSnoop, 32'h0000_0024, 32'h0000_0001, 4'd0, 4'd2},
    '{opRead,  32'h0000_0020, 32'h0000_0000, 4'd2, 4'd0},
    '{opSnoop, 32'h0000_03A0, 32'h0000_0001, 4'd0, 4'd0},  // same index, other tag
    '{opRead,  32'h0000_0024, 32'h0000_0000, 4'd0, 4'd0},
    '{opSnoop, 32'h0000_0010, 32'h0000_0001, 4'd0, 4'd0},  // clean frame dropped
    '{opRead,  32'h0000_0010, 32'h0000_0000, 4'd2, 4'd0},
    '{opWrite, 32'h0000_0040, 32'h1234_5678, 4'd2, 4'd0},
    '{opWrite, 32'h0000_01F8, 32'h5A5A_0003, 4'd2, 4'd0},
    '{opWrite, 32'h0000_003C, 32'h0F0F_0004, 4'd2, 4'd0},
    '{opWrite, 32'h0000_0044, 32'h8765_4321, 4'd0, 4'd0},
    '{opSnoop, 32'h0000_01FC, 32'h0000_0000, 4'd0, 4'd2},  // written back but stays valid
    '{opRead,  32'h0000_01F8, 32'h0000_0000, 4'd0, 4'd0},
    '{opFlush, 32'h0000_0000, 32'h0000_0000, 4'd0, 4'd4}   // frames 7 and 8
  };

  logic CLK = 1'b0;
  logic nRST, dmemREN, dmemWEN, flush, dwait, ccwait, ccwrite, ccinv;
  logic dhit, halt, dREN, dWEN, snoopable;
  dcachePkg::addrT dmemAddr, ccAddr, daddr;
  dcachePkg::wordT dmemStore, dload, dmemLoad, dstore;

  logic [31:0] memImg [256];
  logic [31:0] golden [256];
  logic [31:0] lfsr = 32'h8193_e7e2;
  logic [1:0]  waitCnt = 2'd0;
  int rdCnt = 0;
  int wrCnt = 0;
  int errors = 0;
  int checks = 0;

  dcache dut_i (.*);

  always #5 CLK = ~CLK;

  assign dload = memImg[daddr[9:2]];

  function automatic logic [31:0] galoisStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ POLY) : (s >> 1);
  endfunction

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = galoisStep(lfsr);
    end
    return r;
  endfunction

  // word transfer completes on an edge with dwait low
  always @(posedge CLK) begin : memModel
    logic [1:0] w;
    if (dREN || dWEN) begin
      if (!dwait) begin
        if (dWEN) begin
          memImg[daddr[9:2]] <= dstore;
          wrCnt <= wrCnt + 1;
        end else begin
          rdCnt <= rdCnt + 1;
        end
        w = 2'(takeBits(2));   // wait for the next word
        waitCnt <= w;
        dwait <= (w != 2'd0);
      end else begin
        waitCnt <= waitCnt - 2'd1;
        if (waitCnt == 2'd1) dwait <= 1'b0;
      end
    end
  end

  task automatic runStep(input int idx, input stepT s);
    int rd0, wr0, waitCyc;
    logic [31:0] got;
    logic snoopSeen;
    @(negedge CLK);
    rd0 = rdCnt;
    wr0 = wrCnt;
    @(posedge CLK);
    case (s.op)
      opRead, opWrite: begin
        dmemREN   <= (s.op == opRead);
        dmemWEN   <= (s.op == opWrite);
        dmemAddr  <= s.addr;
        dmemStore <= s.data;
        waitCyc = 0;
        do begin
          @(negedge CLK);
          waitCyc++;
        end while (!dhit);
        got = dmemLoad;
        // a hit answers in the request cycle
        if (s.nRd == 0 && s.nWr == 0) begin
          checks++;
          if (waitCyc != 1) begin
            errors++;
            $display("MISMATCH at %0t: step %0d hit took %0d cycles, expected 1",
                     $time, idx, waitCyc);
          end
        end
        @(posedge CLK);
        dmemREN <= 1'b0;
        dmemWEN <= 1'b0;
        if (s.op == opWrite) begin
          golden[s.addr[9:2]] = s.data;
        end else begin
          checks++;
          if (got !== golden[s.addr[9:2]]) begin
            errors++;
            $display("MISMATCH at %0t: step %0d read %h gave %h, expected %h",
                     $time, idx, s.addr, got, golden[s.addr[9:2]]);
          end
        end
      end
      opSnoop: begin
        ccwait  <= 1'b1;
        ccwrite <= 1'b1;
        ccinv   <= s.data[0];
        ccAddr  <= s.addr;
        @(negedge CLK);
        do @(negedge CLK); while (dWEN);   // served once the cache is quiet
        @(posedge CLK);
        ccwait  <= 1'b0;
        ccwrite <= 1'b0;
        ccinv   <= 1'b0;
      end
      default: begin
        flush <= 1'b1;
        snoopSeen = 1'b0;
        do begin
          @(negedge CLK);
          if (snoopable) begin
            snoopSeen = 1'b1;
          end
          checks++;
          // write-back cycles of the walk cannot take a snoop
          if (snoopable && (dREN || dWEN)) begin
            errors++;
            $display("MISMATCH at %0t: step %0d snoopable high during a flush write",
                     $time, idx);
          end
        end while (!halt);
        checks++;
        if (!snoopSeen) begin
          errors++;
          $display("MISMATCH at %0t: step %0d snoopable never rose during the flush",
                   $time, idx);
        end
        @(posedge CLK);
        flush <= 1'b0;
      end
    endcase
    @(negedge CLK);
    checks++;
    if (rdCnt - rd0 != s.nRd || wrCnt - wr0 != s.nWr) begin
      errors++;
      $display("MISMATCH at %0t: step %0d made %0d reads, %0d writes, expected %0d, %0d",
               $time, idx, rdCnt - rd0, wrCnt - wr0, s.nRd, s.nWr);
    end
  endtask

  initial begin : stimulus
    logic [31:0] w;
    for (int i = 0; i < 256; i++) begin
      w = takeBits(32);
      memImg[i] <= w;
      golden[i] = w;
    end
    nRST <= 1'b0;
    dmemREN <= 1'b0;
    dmemWEN <= 1'b0;
    flush <= 1'b0;
    dmemAddr <= '0;
    dmemStore <= '0;
    dwait <= 1'b0;
    ccwait <= 1'b0;
    ccwrite <= 1'b0;
    ccinv <= 1'b0;
    ccAddr <= '0;
    repeat (10) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    checks++;
    if (dREN || dWEN || dhit || halt || snoopable) begin
      errors++;
      $display("MISMATCH at %0t: outputs not quiet after reset", $time);
    end
    for (int i = 0; i < NSTEPS; i++) begin
      runStep(i, steps[i]);
    end
    for (int i = 0; i < 256; i++) begin
      checks++;
      if (memImg[i] !== golden[i]) begin
        errors++;
        $display("MISMATCH at %0t: memory word %0d is %h, expected %h",
                 $time, i, memImg[i], golden[i]);
      end
    end
    repeat (5) begin
      @(negedge CLK);
      checks++;
      if (!halt || dREN || dWEN || snoopable) begin
        errors++;
        $display("MISMATCH at %0t: halt %b dREN %b dWEN %b snoopable %b after flush",
                 $time, halt, dREN, dWEN, snoopable);
      end
    end
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (NSTEPS * 200 + 20) @(posedge CLK);
    $display("watchdog expired before the last step finished");
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* test/dcache_properties.sv */
`default_nettype none

module dcacheProps (
  input logic CLK,
  input logic nRST,
  input logic dREN,
  input logic dWEN,
  input logic dwait,
  input logic halt,
  input dcachePkg::addrT daddr,
  input dcachePkg::wordT dstore
);
  timeunit 1ns;
  timeprecision 1ps;

  oneDirection: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
    else $error("dREN and dWEN high in the same cycle");

  // memory back-pressure
  holdWhileWait: assert property (@(posedge CLK) disable iff (!nRST)
    ((dREN || dWEN) && dwait) |=> ($stable(daddr) && $stable(dstore)))
    else $error("daddr or dstore changed while dwait was high");

  haltSticks: assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
    else $error("halt fell without a reset");

  quietWhenHalted: assert property (@(posedge CLK) disable iff (!nRST)
    halt |-> !(dREN || dWEN))
    else $error("memory request while halt is high");

endmodule

bind dcache dcacheProps props_i (.*);

`default_nettype wire

/* rtl/dcache.sv */
`default_nettype none

module dcache (
  input  logic CLK,
  input  logic nRST,
  input  logic dmemREN,
  input  logic dmemWEN,
  input  logic flush,
  input  dcachePkg::addrT dmemAddr,
  input  dcachePkg::wordT dmemStore,
  input  dcachePkg::wordT dload,
  input  logic dwait,
  input  logic ccwait,
  input  logic ccwrite,
  input  logic ccinv,
  input  dcachePkg::addrT ccAddr,
  output dcachePkg::wordT dmemLoad,
  output logic dhit,
  output logic halt,
  output logic dREN,
  output logic dWEN,
  output dcachePkg::addrT daddr,
  output dcachePkg::wordT dstore,
  output logic snoopable
);

  logic hit, dirty, snoopHit, snoopDirty, sameAddr;
  logic blockOff, fillWe, invalid, flctUp, flushing, snoopSel;
  logic hitWrite, wbDone;
  logic [dcachePkg::FLCTW-1:0] flctOut;

  assign dhit = hit & hitWrite;   // hitWrite is high only in idle

  dcacheCtrl ctrl_i (
    .CLK(CLK),
    .nRST(nRST),
    .dmemREN(dmemREN),
    .dmemWEN(dmemWEN),
    .flush(flush),
    .hit(hit),
    .dirty(dirty),
    .snoopHit(snoopHit),
    .snoopDirty(snoopDirty),
    .sameAddr(sameAddr),
    .dwait(dwait),
    .ccwait(ccwait),
    .ccwrite(ccwrite),
    .ccinv(ccinv),
    .flctOut(flctOut),
    .dREN(dREN),
    .dWEN(dWEN),
    .blockOff(blockOff),
    .fillWe(fillWe),
    .invalid(invalid),
    .flctUp(flctUp),
    .flushing(flushing),
    .snoopSel(snoopSel),
    .snoopable(snoopable),
    .halt(halt),
    .hitWrite(hitWrite),
    .wbDone(wbDone)
  );

  dcacheFrames frames_i (
    .CLK(CLK),
    .nRST(nRST),
    .dmemAddr(dmemAddr),
    .ccAddr(ccAddr),
    .dmemStore(dmemStore),
    .dmemWEN(dmemWEN),
    .fillWe(fillWe),
    .blockOff(blockOff),
    .invalid(invalid),
    .flctUp(flctUp),
    .flushing(flushing),
    .snoopSel(snoopSel),
    .hitWrite(hitWrite),
    .wbDone(wbDone),
    .dload(dload),
    .hit(hit),
    .dirty(dirty),
    .snoopHit(snoopHit),
    .snoopDirty(snoopDirty),
    .sameAddr(sameAddr),
    .flctOut(flctOut),
    .dmemLoad(dmemLoad),
    .dstore(dstore),
    .daddr(daddr)
  );

endmodule

`default_nettype wire

/* rtl/dcacheFrames.sv */
`default_nettype none

module dcacheFrames (
  input  logic CLK,
  input  logic nRST,
  input  dcachePkg::addrT dmemAddr,
  input  dcachePkg::addrT ccAddr,
  input  dcachePkg::wordT dmemStore,
  input  logic dmemWEN,
  input  logic fillWe,
  input  logic blockOff,
  input  logic invalid,
  input  logic flctUp,
  input  logic flushing,
  input  logic snoopSel,
  input  logic hitWrite,
  input  logic wbDone,
  input  dcachePkg::wordT dload,
  output logic hit,
  output logic dirty,
  output logic snoopHit,
  output logic snoopDirty,
  output logic sameAddr,
  output logic [dcachePkg::FLCTW-1:0] flctOut,
  output dcachePkg::wordT dmemLoad,
  output dcachePkg::wordT dstore,
  output dcachePkg::addrT daddr
);

  dcachePkg::tagT   tagQ  [dcachePkg::NFRAMES];
  dcachePkg::wordT  dataQ [dcachePkg::NFRAMES][2];
  logic [dcachePkg::NFRAMES-1:0] validQ, dirtyQ;
  logic [dcachePkg::FLCTW-1:0]   flctQ;

  dcachePkg::tagT   coreTag, ccTag, selTag;
  dcachePkg::indexT coreIdx, ccIdx, flIdx, selIdx;
  logic coreOff, coreWrite;

  assign coreTag = dmemAddr[31:7];
  assign coreIdx = dmemAddr[6:3];
  assign coreOff = dmemAddr[2];
  assign ccTag   = ccAddr[31:7];
  assign ccIdx   = ccAddr[6:3];
  assign flIdx   = flctQ[3:0];

  // flush counter wins over snoop, snoop over core
  assign selIdx = flushing ? flIdx : (snoopSel ? ccIdx : coreIdx);

  assign hit        = validQ[coreIdx] & (tagQ[coreIdx] == coreTag);
  assign snoopHit   = validQ[ccIdx] & (tagQ[ccIdx] == ccTag);
  assign snoopDirty = dirtyQ[ccIdx];
  assign dirty      = dirtyQ[selIdx];
  assign sameAddr   = (ccIdx == flIdx);
  assign flctOut    = flctQ;
  assign coreWrite  = hitWrite & dmemWEN & hit;

  assign dmemLoad = dataQ[coreIdx][coreOff];
  assign dstore   = dataQ[selIdx][blockOff];

  // dirty frame is being written out, else the block is being fetched
  assign selTag = dirtyQ[selIdx] ? tagQ[selIdx] : coreTag;
  assign daddr  = {selTag, selIdx, blockOff, 2'b00};

  always_ff @(posedge CLK) begin : frameData
    if (fillWe) begin
      dataQ[selIdx][blockOff] <= dload;
      if (blockOff) begin
        tagQ[selIdx] <= coreTag;
      end
    end
    if (coreWrite) begin
      dataQ[coreIdx][coreOff] <= dmemStore;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin : frameState
    if (!nRST) begin
      validQ <= '0;
      dirtyQ <= '0;
    end else begin
      if (fillWe) begin
        validQ[selIdx] <= blockOff;   // block usable after second word
        dirtyQ[selIdx] <= 1'b0;
      end
      if (coreWrite) begin
        dirtyQ[coreIdx] <= 1'b1;
      end
      if (wbDone) begin
        dirtyQ[selIdx] <= 1'b0;
      end
      if (invalid) begin
        validQ[selIdx] <= 1'b0;
        dirtyQ[selIdx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin : flushCounter
    if (!nRST) begin
      flctQ <= '0;
    end else if (flctUp) begin
      flctQ <= flctQ + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/dcacheCtrl.sv */
`default_nettype none

module dcacheCtrl (
  input  logic CLK,
  input  logic nRST,
  input  logic dmemREN,
  input  logic dmemWEN,
  input  logic flush,
  input  logic hit,
  input  logic dirty,
  input  logic snoopHit,
  input  logic snoopDirty,
  input  logic sameAddr,
  input  logic dwait,
  input  logic ccwait,
  input  logic ccwrite,
  input  logic ccinv,
  input  logic [dcachePkg::FLCTW-1:0] flctOut,
  output logic dREN,
  output logic dWEN,
  output logic blockOff,
  output logic fillWe,
  output logic invalid,
  output logic flctUp,
  output logic flushing,
  output logic snoopSel,
  output logic snoopable,
  output logic halt,
  output logic hitWrite,
  output logic wbDone
);

  dcachePkg::ctrlStateT state, nextState;
  logic miss, snoopReq, flDone;

  assign miss     = (dmemREN | dmemWEN) & ~hit;
  assign snoopReq = ccwait & ccwrite;
  assign flDone   = (flctOut == dcachePkg::FLEND);

  always_comb begin : nextStateLogic
    nextState = state;
    case (state)
      dcachePkg::idle: begin
        if (miss && !ccwait) begin
          nextState = dirty ? dcachePkg::wbVictim0 : dcachePkg::fill0;
        end else if (snoopReq && snoopHit && snoopDirty) begin
          nextState = dcachePkg::wbSnoop0;
        end else if (flush) begin
          nextState = dcachePkg::flStart;
        end
      end
      dcachePkg::wbVictim0: if (!dwait) nextState = dcachePkg::wbVictim1;
      dcachePkg::wbVictim1: if (!dwait) nextState = dcachePkg::fill0;
      dcachePkg::wbSnoop0:  if (!dwait) nextState = dcachePkg::wbSnoop1;
      dcachePkg::wbSnoop1:  if (!dwait) nextState = dcachePkg::idle;
      dcachePkg::fill0:     if (!dwait) nextState = dcachePkg::fill1;
      dcachePkg::fill1:     if (!dwait) nextState = dcachePkg::idle;
      dcachePkg::flStart: begin
        // clean frames are counted off in place, one per cycle
        if (flDone) begin
          nextState = dcachePkg::halted;
        end else if (dirty) begin
          nextState = dcachePkg::flPre;
        end
      end
      dcachePkg::flPre:     nextState = dcachePkg::flush0;
      dcachePkg::flush0:    if (!dwait) nextState = dcachePkg::flush1;
      dcachePkg::flush1:    if (!dwait) nextState = dcachePkg::flCount;
      dcachePkg::flCount:   nextState = dcachePkg::flStart;
      dcachePkg::halted:    nextState = dcachePkg::halted;
      default:              nextState = dcachePkg::idle;
    endcase
  end

  always_comb begin : outputLogic
    dREN      = 1'b0;
    dWEN      = 1'b0;
    blockOff  = 1'b0;
    fillWe    = 1'b0;
    invalid   = 1'b0;
    flctUp    = 1'b0;
    flushing  = 1'b0;
    snoopSel  = 1'b0;
    snoopable = 1'b0;
    halt      = 1'b0;
    hitWrite  = 1'b0;
    wbDone    = 1'b0;
    case (state)
      dcachePkg::idle: begin
        hitWrite = 1'b1;       // hits served only here
        snoopSel = snoopReq;
        // clean matching frame is dropped without bus traffic
        invalid  = snoopReq & ccinv & snoopHit & ~snoopDirty;
      end
      dcachePkg::wbVictim0: begin
        dWEN = 1'b1;
      end
      dcachePkg::wbVictim1: begin
        dWEN     = 1'b1;
        blockOff = 1'b1;
        wbDone   = ~dwait;
      end
      dcachePkg::wbSnoop0: begin
        dWEN     = 1'b1;
        snoopSel = 1'b1;
      end
      dcachePkg::wbSnoop1: begin
        dWEN     = 1'b1;
        snoopSel = 1'b1;
        blockOff = 1'b1;
        wbDone   = ~dwait;
        invalid  = ~dwait & ccinv;
      end
      dcachePkg::fill0: begin
        dREN   = 1'b1;
        fillWe = ~dwait;
      end
      dcachePkg::fill1: begin
        dREN     = 1'b1;
        blockOff = 1'b1;
        fillWe   = ~dwait;
      end
      dcachePkg::flStart: begin
        flushing  = 1'b1;
        snoopable = 1'b1;
        flctUp    = ~flDone & ~dirty;
      end
      dcachePkg::flPre: begin
        flushing  = 1'b1;
        snoopable = 1'b1;
      end
      dcachePkg::flush0: begin
        flushing = 1'b1;
        dWEN     = 1'b1;
      end
      dcachePkg::flush1: begin
        flushing = 1'b1;
        dWEN     = 1'b1;
        blockOff = 1'b1;
        wbDone   = ~dwait;
        // a pending invalidating snoop on this frame is served by this write-back
        invalid  = ~dwait & snoopReq & ccinv & sameAddr;
      end
      dcachePkg::flCount: begin
        flushing  = 1'b1;
        snoopable = 1'b1;
        flctUp    = 1'b1;
      end
      dcachePkg::halted: begin
        halt = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin : stateReg
    if (!nRST) begin
      state <= dcachePkg::idle;
    end else begin
      state <= nextState;
    end
  end

endmodule

`default_nettype wire

/* rtl/dcachePkg.sv */
`default_nettype none

package dcachePkg;

  // 16 direct-mapped frames of two words
  localparam int NFRAMES = 16;
  localparam int FLCTW   = 5;

  // flush counter value once every frame has been visited
  localparam logic [FLCTW-1:0] FLEND = FLCTW'(NFRAMES);

  typedef logic [31:0] wordT;
  typedef logic [31:0] addrT;   // tag 31:7, index 6:3, offset 2, byte 1:0 ignored
  typedef logic [24:0] tagT;
  typedef logic [3:0]  indexT;

  typedef enum logic [3:0] {
    idle,
    wbVictim0,
    wbVictim1,
    wbSnoop0,
    wbSnoop1,
    fill0,
    fill1,
    flStart,
    flPre,
    flush0,
    flush1,
    flCount,
    halted
  } ctrlStateT;

endpackage

`default_nettype wire
